// File: rtl/usb_pkg.sv
`default_nettype none

package usb_pkg;

   // Width of one byte on the FT2232H FIFO data bus
   localparam int USB_DATA_WIDTH = 8;

   // Synchronous write FSM of the transmitter
   //   TX_IDLE  : WR# high, waiting for a byte and a ready chip
   //   TX_WRITE : WR# low, byte on the bus for one clock
   //   TX_HOLD  : byte was refused, kept on the bus until TXE# falls
   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,
      TX_WRITE = 2'd1,
      TX_HOLD  = 2'd2
   } ft_state_e;

endpackage

`default_nettype wire

// File: rtl/pattern_pkg.sv
`default_nettype none

package pattern_pkg;

   // Test pattern selection
   typedef enum logic {
      PAT_RAMP   = 1'b0,
      PAT_TOGGLE = 1'b1
   } pattern_mode_e;

   // Toggle mode alternates these two bytes, starting with TOGGLE_A
   localparam logic [usb_pkg::USB_DATA_WIDTH-1:0] TOGGLE_A = 8'h55;
   localparam logic [usb_pkg::USB_DATA_WIDTH-1:0] TOGGLE_B = 8'hAA;

endpackage

`default_nettype wire

// File: rtl/fifo_wr_if.sv
`timescale 1ns/1ns
`default_nettype none

// Write side of the clock crossing FIFO, clk_80mhz domain.
// A byte is taken at an edge where wen is high and full is low.
interface fifo_wr_if;

   logic [usb_pkg::USB_DATA_WIDTH-1:0] data;
   logic                               wen;
   logic                               full;
   // Rises with a few free slots left to absorb the producer's lag
   logic                               almost_full;

   modport producer (
      output data,
      output wen,
      input  full,
      input  almost_full
   );

   modport consumer (
      input  data,
      input  wen,
      output full,
      output almost_full
   );

endinterface

`default_nettype wire

// File: rtl/pattern_gen.sv
`timescale 1ns/1ns
`default_nettype none

module pattern_gen #(
   parameter int FIFO_ADDR_WIDTH = 10
) (
   input  logic                       clk_80mhz,
   input  logic                       rst_n,
   input  logic                       enable_i,
   input  pattern_pkg::pattern_mode_e mode_i,
   fifo_wr_if.producer                wr
);

   localparam int DW = usb_pkg::USB_DATA_WIDTH;

   logic [DW-1:0] ramp_q;
   logic          toggle_q;
   logic          wen_q;
   logic [DW-1:0] data_q;
   logic [DW-1:0] next_byte;
   logic          issue;

   // Depth of at least 4 is needed for the almost-full margin to make sense
   if (FIFO_ADDR_WIDTH < 2) begin : g_depth_check
      $error("pattern_gen: FIFO_ADDR_WIDTH must be at least 2");
   end

   // Decide on this cycle, write on the next one
   assign issue = enable_i && !wr.almost_full;

   always_comb begin
      unique case (mode_i)
         pattern_pkg::PAT_TOGGLE: next_byte = toggle_q ? pattern_pkg::TOGGLE_B
                                                       : pattern_pkg::TOGGLE_A;
         default:                 next_byte = ramp_q;
      endcase
   end

   // Pattern state moves only when a byte is issued, so stalls leave no gaps
   always_ff @(posedge clk_80mhz) begin
      if (!rst_n) begin
         ramp_q   <= '0;
         toggle_q <= 1'b0;
         wen_q    <= 1'b0;
      end else begin
         wen_q <= issue;
         if (issue) begin
            if (mode_i == pattern_pkg::PAT_TOGGLE) begin
               toggle_q <= !toggle_q;
            end else begin
               ramp_q <= ramp_q + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_80mhz) begin
      if (issue) begin
         data_q <= next_byte;
      end
   end

   assign wr.wen  = wen_q;
   assign wr.data = data_q;

endmodule

`default_nettype wire

// File: rtl/async_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module async_fifo #(
   parameter int FIFO_ADDR_WIDTH = 10,
   parameter int AFULL_MARGIN    = 4
) (
   // Write domain
   input  logic                              clk_80mhz,
   input  logic                              rst_n,
   fifo_wr_if.consumer                       wr,
   // Read domain
   input  logic                              rclk_i,
   input  logic                              rrst_n_i,
   input  logic                              ren_i,
   output logic [usb_pkg::USB_DATA_WIDTH-1:0] rdata_o,
   output logic                              empty_o,
   output logic                              full_o
);

   localparam int AW = FIFO_ADDR_WIDTH;
   localparam int DW = usb_pkg::USB_DATA_WIDTH;

   localparam logic [AW:0] FULL_LEVEL  = (AW+1)'(1 << AW);
   localparam logic [AW:0] AFULL_LEVEL = FULL_LEVEL - (AW+1)'(AFULL_MARGIN);

   // Write side stays almost-full after reset until the read side has
   // left its own, later reset and its pointer has crossed over
   localparam int HOLDOFF_CYCLES = 16;
   localparam int HW             = $clog2(HOLDOFF_CYCLES + 1);

   logic [DW-1:0] mem [0:(1 << AW)-1];

   // Write domain
   logic [AW:0]   wbin_q;
   logic [AW:0]   wbin_next;
   logic [AW:0]   wgray_q;
   logic [AW:0]   rgray_w1_q;
   logic [AW:0]   rgray_w2_q;
   logic [AW:0]   rbin_w;
   logic [AW:0]   wlevel;
   logic [HW-1:0] holdoff_q;
   logic          wr_ready;
   logic          full;
   logic          wr_fire;

   // Read domain
   logic [AW:0]   rbin_q;
   logic [AW:0]   rbin_next;
   logic [AW:0]   rgray_q;
   logic [AW:0]   wgray_r1_q;
   logic [AW:0]   wgray_r2_q;
   logic          rd_fire;

   function automatic logic [AW:0] bin_to_gray(input logic [AW:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [AW:0] gray_to_bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Fill level seen by the writer, lags reads by the synchronizer
   assign rbin_w    = gray_to_bin(rgray_w2_q);
   assign wlevel    = wbin_q - rbin_w;
   assign wr_ready  = (holdoff_q == HW'(HOLDOFF_CYCLES));
   assign full      = (wlevel == FULL_LEVEL);
   assign wr_fire   = wr.wen && !full;
   assign wbin_next = wbin_q + 1'b1;

   assign wr.full        = full;
   assign wr.almost_full = !wr_ready || (wlevel >= AFULL_LEVEL);
   assign full_o         = full;

   always_ff @(posedge clk_80mhz) begin
      if (!rst_n) begin
         wbin_q     <= '0;
         wgray_q    <= '0;
         rgray_w1_q <= '0;
         rgray_w2_q <= '0;
         holdoff_q  <= '0;
      end else begin
         rgray_w1_q <= rgray_q;
         rgray_w2_q <= rgray_w1_q;
         if (!wr_ready) begin
            holdoff_q <= holdoff_q + 1'b1;
         end
         if (wr_fire) begin
            wbin_q  <= wbin_next;
            wgray_q <= bin_to_gray(wbin_next);
         end
      end
   end

   always_ff @(posedge clk_80mhz) begin
      if (wr_fire) begin
         mem[wbin_q[AW-1:0]] <= wr.data;
      end
   end

   // Empty as soon as the read pointer catches the synchronized write pointer
   assign empty_o   = (rgray_q == wgray_r2_q);
   assign rd_fire   = ren_i && !empty_o;
   assign rbin_next = rbin_q + 1'b1;

   // Show-ahead, the head byte is visible without a read strobe
   assign rdata_o = mem[rbin_q[AW-1:0]];

   always_ff @(posedge rclk_i) begin
      if (!rrst_n_i) begin
         rbin_q     <= '0;
         rgray_q    <= '0;
         wgray_r1_q <= '0;
         wgray_r2_q <= '0;
      end else begin
         wgray_r1_q <= wgray_q;
         wgray_r2_q <= wgray_r1_q;
         if (rd_fire) begin
            rbin_q  <= rbin_next;
            rgray_q <= bin_to_gray(rbin_next);
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/ft_sync_tx.sv
`timescale 1ns/1ns
`default_nettype none

module ft_sync_tx (
   input  logic                              ft_clk_i,
   input  logic                              rst_n_i,
   // Chip status, both active low
   input  logic                              ft_txe_n_i,
   input  logic                              ft_suspend_n_i,
   // Show-ahead FIFO read port
   input  logic [usb_pkg::USB_DATA_WIDTH-1:0] fifo_rdata_i,
   input  logic                              fifo_empty_i,
   output logic                              fifo_ren_o,
   // Toward the chip
   output logic [usb_pkg::USB_DATA_WIDTH-1:0] ft_data_o,
   output logic                              ft_wr_n_o
);

   usb_pkg::ft_state_e                 state_q;
   logic                               wr_n_q;
   logic [usb_pkg::USB_DATA_WIDTH-1:0] data_q;
   logic                               chip_ready;
   logic                               load_new;
   logic                               accepted;
   logic                               refused;

   // Room in the chip and USB not suspended
   assign chip_ready = !ft_txe_n_i && ft_suspend_n_i;
   assign load_new   = (state_q == usb_pkg::TX_IDLE) && chip_ready && !fifo_empty_i;

   // Chip samples WR# and TXE# on the same edge
   assign accepted = (state_q == usb_pkg::TX_WRITE) && !ft_txe_n_i;
   assign refused  = (state_q == usb_pkg::TX_WRITE) && ft_txe_n_i;

   // FIFO head is popped only once the chip has taken it
   assign fifo_ren_o = accepted;

   always_ff @(posedge ft_clk_i) begin
      if (!rst_n_i) begin
         state_q <= usb_pkg::TX_IDLE;
         wr_n_q  <= 1'b1;
      end else begin
         unique case (state_q)
            usb_pkg::TX_IDLE: begin
               if (load_new) begin
                  state_q <= usb_pkg::TX_WRITE;
                  wr_n_q  <= 1'b0;
               end
            end
            usb_pkg::TX_WRITE: begin
               // One strobe per byte, a refused byte waits in HOLD
               wr_n_q  <= 1'b1;
               state_q <= refused ? usb_pkg::TX_HOLD : usb_pkg::TX_IDLE;
            end
            usb_pkg::TX_HOLD: begin
               if (chip_ready) begin
                  state_q <= usb_pkg::TX_WRITE;
                  wr_n_q  <= 1'b0;
               end
            end
            default: begin
               state_q <= usb_pkg::TX_IDLE;
               wr_n_q  <= 1'b1;
            end
         endcase
      end
   end

   // Loaded only from IDLE, so a refused byte stays on the bus for replay
   always_ff @(posedge ft_clk_i) begin
      if (load_new) begin
         data_q <= fifo_rdata_i;
      end
   end

   assign ft_data_o = data_q;
   assign ft_wr_n_o = wr_n_q;

endmodule

`default_nettype wire

// File: rtl/usb_tx_top.sv
`timescale 1ns/1ns
`default_nettype none

module usb_tx_top #(
   parameter int FIFO_ADDR_WIDTH = 10,
   parameter int AFULL_MARGIN    = 4
) (
   input  logic                              clk_80mhz,
   input  logic                              rst_n,
   input  logic                              gen_enable_i,
   input  pattern_pkg::pattern_mode_e        pattern_mode_i,
   // FT2232H synchronous FIFO, 60 MHz from the chip
   input  logic                              ft_clkout_i,
   input  logic                              ft_txe_n_i,
   input  logic                              ft_suspend_n_i,
   output logic [usb_pkg::USB_DATA_WIDTH-1:0] ft_data_o,
   output logic                              ft_wr_n_o,
   output logic                              ft_rd_n_o,
   output logic                              ft_oe_n_o,
   output logic                              ft_siwua_n_o,
   // Status
   output logic                              fifo_full_o,
   output logic                              fifo_empty_o
);

   logic [1:0]                         rrst_n_sync_q;
   logic                               rrst_n;
   logic                               fifo_ren;
   logic [usb_pkg::USB_DATA_WIDTH-1:0] fifo_rdata;

   fifo_wr_if i_fifo_wr ();

   // Reset into the chip clock domain, a single low sample still passes through
   always_ff @(posedge ft_clkout_i) begin
      rrst_n_sync_q <= {rrst_n_sync_q[0], rst_n};
   end

   assign rrst_n = rrst_n_sync_q[1];

   pattern_gen #(
      .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
   ) i_pattern_gen (
      .clk_80mhz (clk_80mhz),
      .rst_n     (rst_n),
      .enable_i  (gen_enable_i),
      .mode_i    (pattern_mode_i),
      .wr        (i_fifo_wr.producer)
   );

   async_fifo #(
      .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH),
      .AFULL_MARGIN    (AFULL_MARGIN)
   ) i_async_fifo (
      .clk_80mhz (clk_80mhz),
      .rst_n     (rst_n),
      .wr        (i_fifo_wr.consumer),
      .rclk_i    (ft_clkout_i),
      .rrst_n_i  (rrst_n),
      .ren_i     (fifo_ren),
      .rdata_o   (fifo_rdata),
      .empty_o   (fifo_empty_o),
      .full_o    (fifo_full_o)
   );

   ft_sync_tx i_ft_sync_tx (
      .ft_clk_i       (ft_clkout_i),
      .rst_n_i        (rrst_n),
      .ft_txe_n_i     (ft_txe_n_i),
      .ft_suspend_n_i (ft_suspend_n_i),
      .fifo_rdata_i   (fifo_rdata),
      .fifo_empty_i   (fifo_empty_o),
      .fifo_ren_o     (fifo_ren),
      .ft_data_o      (ft_data_o),
      .ft_wr_n_o      (ft_wr_n_o)
   );

   // Write-only link, read direction and send-immediate stay idle
   assign ft_rd_n_o    = 1'b1;
   assign ft_oe_n_o    = 1'b1;
   assign ft_siwua_n_o = 1'b1;

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS = 4
) (
   output logic clk_o
);

   // Free-running clock, starts low
   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2);
         clk_o = ~clk_o;
      end
   end

endmodule

`default_nettype wire

// File: dv/usb_tx_properties.sv
`timescale 1ns/1ns
`default_nettype none

module usb_tx_properties (
   input logic                               ft_clk_i,
   input logic                               rst_n_i,
   input logic                               ft_txe_n_i,
   input logic                               ft_suspend_n_i,
   input logic                               fifo_ren_i,
   input logic [usb_pkg::USB_DATA_WIDTH-1:0] ft_data_i,
   input logic                               ft_wr_n_i,
   input usb_pkg::ft_state_e                 state_i
);

   // Number of failed assertions so far
   int unsigned assert_fail_count = 0;

   // WR# may only fall on an edge where the chip was not suspended
   a_no_strobe_in_suspend: assert property (
      @(posedge ft_clk_i) disable iff (!rst_n_i)
      $fell(ft_wr_n_i) |-> $past(ft_suspend_n_i)
   ) else begin
      assert_fail_count++;
      $error("WR# fell on an edge where the chip was suspended");
   end

   // A refused byte stays on the bus
   a_refused_held: assert property (
      @(posedge ft_clk_i) disable iff (!rst_n_i)
      (!ft_wr_n_i && ft_txe_n_i) |=> $stable(ft_data_i)
   ) else begin
      assert_fail_count++;
      $error("refused byte was not held on the data bus");
   end

   a_hold_stable: assert property (
      @(posedge ft_clk_i) disable iff (!rst_n_i)
      (state_i == usb_pkg::TX_HOLD) |=> $stable(ft_data_i)
   ) else begin
      assert_fail_count++;
      $error("data bus changed while a byte was held");
   end

   // FIFO pops exactly at accepted bytes
   a_pop_on_accept: assert property (
      @(posedge ft_clk_i) disable iff (!rst_n_i)
      fifo_ren_i == (!ft_wr_n_i && !ft_txe_n_i)
   ) else begin
      assert_fail_count++;
      $error("FIFO read strobe does not match an accepted byte");
   end

endmodule

bind ft_sync_tx usb_tx_properties i_tx_props (
   .ft_clk_i       (ft_clk_i),
   .rst_n_i        (rst_n_i),
   .ft_txe_n_i     (ft_txe_n_i),
   .ft_suspend_n_i (ft_suspend_n_i),
   .fifo_ren_i     (fifo_ren_o),
   .ft_data_i      (ft_data_o),
   .ft_wr_n_i      (ft_wr_n_o),
   .state_i        (state_q)
);

`default_nettype wire

// File: dv/usb_tx_tb.sv
`timescale 1ns/1ns
`default_nettype none

module usb_tx_tb;

   localparam int          FIELDS       = 6;
   localparam int          MAX_PHASES   = 16;
   // Small FIFO so back-pressure reaches the full flag quickly;
   // a margin of one still covers the generator's one cycle of lag
   localparam int          FIFO_AW      = 5;
   localparam int          AFULL_MARGIN = 1;
   localparam int          BYTE_TIMEOUT = 1000;
   localparam int          FULL_TIMEOUT = 1000;
   localparam logic [15:0] END_MARK     = 16'hFFFF;

   logic                               clk_80mhz;
   logic                               ft_clkout;
   logic                               rst_n;
   logic                               gen_enable;
   pattern_pkg::pattern_mode_e         pattern_mode;
   logic                               ft_txe_n;
   logic                               ft_suspend_n;
   logic [usb_pkg::USB_DATA_WIDTH-1:0] ft_data;
   logic                               ft_wr_n;
   logic                               ft_rd_n;
   logic                               ft_oe_n;
   logic                               ft_siwua_n;
   logic                               fifo_full;
   logic                               fifo_empty;

   logic [15:0] stim_mem [0:MAX_PHASES*FIELDS-1];
   int unsigned bytes_total;
   int          phase;

   tb_clock_gen #(.PERIOD_NS (4)) i_sys_clk (.clk_o (clk_80mhz));
   tb_clock_gen #(.PERIOD_NS (6)) i_ft_clk  (.clk_o (ft_clkout));

   usb_tx_top #(
      .FIFO_ADDR_WIDTH (FIFO_AW),
      .AFULL_MARGIN    (AFULL_MARGIN)
   ) i_dut (
      .clk_80mhz      (clk_80mhz),
      .rst_n          (rst_n),
      .gen_enable_i   (gen_enable),
      .pattern_mode_i (pattern_mode),
      .ft_clkout_i    (ft_clkout),
      .ft_txe_n_i     (ft_txe_n),
      .ft_suspend_n_i (ft_suspend_n),
      .ft_data_o      (ft_data),
      .ft_wr_n_o      (ft_wr_n),
      .ft_rd_n_o      (ft_rd_n),
      .ft_oe_n_o      (ft_oe_n),
      .ft_siwua_n_o   (ft_siwua_n),
      .fifo_full_o    (fifo_full),
      .fifo_empty_o   (fifo_empty)
   );

   task automatic fail_run(input string reason);
      $display("ERROR at %0t ns: %s", $time, reason);
      $display("TEST RESULT: FAIL");
      $fatal(1, "%s", reason);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h",
                  $time, name, actual, expected);
         fail_run({"wrong value on ", name});
      end
   endtask

   // Ramp counts up modulo 256, toggle swaps 0x55 and 0xAA
   function automatic logic [7:0] next_expected(input logic toggle, input logic [7:0] cur);
      if (toggle) begin
         return (cur == 8'h55) ? 8'hAA : 8'h55;
      end
      return cur + 8'd1;
   endfunction

   task automatic reset_dut(input pattern_pkg::pattern_mode_e mode);
      @(posedge ft_clkout);
      #1;
      ft_txe_n     = 1'b1;
      ft_suspend_n = 1'b1;
      @(posedge clk_80mhz);
      #1;
      rst_n        = 1'b0;
      gen_enable   = 1'b0;
      pattern_mode = mode;
      repeat (2) @(posedge clk_80mhz);
      #1;
      rst_n = 1'b1;
      // Read side leaves reset through its two-flop synchronizer
      repeat (3) @(posedge ft_clkout);
      @(negedge ft_clkout);
      check_value("ft_wr_n_o", ft_wr_n, 1);
      check_value("ft_rd_n_o", ft_rd_n, 1);
      check_value("ft_oe_n_o", ft_oe_n, 1);
      check_value("ft_siwua_n_o", ft_siwua_n, 1);
      check_value("fifo_empty_o", fifo_empty, 1);
      check_value("fifo_full_o", fifo_full, 0);
      @(posedge clk_80mhz);
      #1;
      gen_enable = 1'b1;
   endtask

   // TXE# is still high from reset, so the FIFO can only fill up
   task automatic wait_for_full();
      int cycles;
      cycles = 0;
      @(negedge clk_80mhz);
      while (fifo_full !== 1'b1) begin
         if (cycles == FULL_TIMEOUT) begin
            fail_run("fifo_full_o never rose while TXE# was held high");
         end
         cycles++;
         @(negedge clk_80mhz);
      end
   endtask

   task automatic run_phase(input int idx);
      logic [15:0]                        mode_f;
      logic [15:0]                        busy;
      logic [15:0]                        susp_cycles;
      logic [15:0]                        fill;
      logic [15:0]                        count;
      logic [15:0]                        first;
      logic [usb_pkg::USB_DATA_WIDTH-1:0] expected;
      int                                 received;
      int                                 idle;
      int                                 susp_left;
      bit                                 susp_started;
      bit                                 susp_low_prev;
      mode_f      = stim_mem[idx*FIELDS];
      busy        = stim_mem[idx*FIELDS+1];
      susp_cycles = stim_mem[idx*FIELDS+2];
      fill        = stim_mem[idx*FIELDS+3];
      count       = stim_mem[idx*FIELDS+4];
      first       = stim_mem[idx*FIELDS+5];
      reset_dut(pattern_pkg::pattern_mode_e'(mode_f[0]));
      if (fill != 0) begin
         wait_for_full();
      end
      expected      = first[7:0];
      received      = 0;
      idle          = 0;
      susp_left     = 0;
      susp_started  = 1'b0;
      susp_low_prev = 1'b0;
      while (received < count) begin
         @(posedge ft_clkout);
         #1;
         ft_txe_n = (($urandom % 100) < busy);
         // Suspend once, halfway through the phase
         if (!susp_started && susp_cycles != 0 && received >= count / 2) begin
            susp_started = 1'b1;
            susp_left    = susp_cycles;
         end
         ft_suspend_n = (susp_left == 0);
         if (susp_left != 0) begin
            susp_left--;
         end
         @(negedge ft_clkout);
         // A strobe in the first suspended cycle was launched before suspend
         if (!ft_suspend_n && susp_low_prev) begin
            check_value("ft_wr_n_o", ft_wr_n, 1);
         end
         susp_low_prev = !ft_suspend_n;
         if (ft_wr_n === 1'b0 && ft_txe_n === 1'b0) begin
            check_value("ft_data_o", ft_data, expected);
            expected = next_expected(mode_f[0], expected);
            received++;
            idle = 0;
         end else if (ft_suspend_n) begin
            idle++;
            if (idle > BYTE_TIMEOUT) begin
               fail_run("no byte was accepted by the chip model for too long");
            end
         end
      end
      bytes_total += received;
      $display("Phase %0d done, %0d bytes received", idx, received);
   endtask

   always @(negedge ft_clkout) begin
      if (i_dut.i_ft_sync_tx.i_tx_props.assert_fail_count != 0) begin
         fail_run("a transmit protocol assertion failed");
      end
   end

   initial begin
      rst_n        = 1'b0;
      gen_enable   = 1'b0;
      pattern_mode = pattern_pkg::PAT_RAMP;
      ft_txe_n     = 1'b1;
      ft_suspend_n = 1'b1;
      bytes_total  = 0;
      void'($urandom(41));
      foreach (stim_mem[i]) begin
         stim_mem[i] = END_MARK;
      end
      $readmemh("dv/usb_tx_stimulus.txt", stim_mem);
      phase = 0;
      while (phase < MAX_PHASES && stim_mem[phase*FIELDS] != END_MARK) begin
         run_phase(phase);
         phase++;
      end
      if (bytes_total != 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         fail_run("the stimulus file held no phase");
      end
   end

endmodule

`default_nettype wire

// File: dv/usb_tx_stimulus.txt
// One phase per line, all fields hex:
// mode (0 ramp, 1 toggle), TXE# busy percent, suspend cycles,
// fill (1 holds TXE# high until the FIFO is full), bytes to receive, first byte
0 00 00 0 0200 00 // ramp, chip always ready, wraps past 0xFF
0 32 00 0 0180 00 // ramp, chip busy half the time
0 32 28 0 0100 00 // ramp with a suspend mid-stream
0 00 14 0 00C0 00 // suspend with the chip otherwise ready
1 00 00 0 0080 55 // toggle, chip always ready
1 32 14 0 0080 55 // toggle, busy and suspended
0 19 00 1 0100 00 // ramp after filling the FIFO
1 32 00 1 0060 55 // toggle after filling the FIFO
0 4B 0A 1 0120 00 // heavy back-pressure with suspend

// File: filelist.f
rtl/usb_pkg.sv
rtl/pattern_pkg.sv
rtl/fifo_wr_if.sv
rtl/pattern_gen.sv
rtl/async_fifo.sv
rtl/ft_sync_tx.sv
rtl/usb_tx_top.sv
dv/tb_clock_gen.sv
dv/usb_tx_properties.sv
dv/usb_tx_tb.sv
